//--- files.f
rtl/hpdc_adapter_pkg.sv
rtl/amo_request_encoder.sv
rtl/amo_response_tracker.sv
rtl/flush_sequencer.sv
rtl/cache_request_mux.sv
rtl/hpdc_store_adapter.sv
testbench/tb_hpdc_store_adapter.sv

//--- rtl/amo_request_encoder.sv
/*
 * AMO request encoder. Translates the core atomic opcode to the cache
 * opcode and aligns write data and byte enables for word accesses.
 */
module amo_request_encoder
    import hpdc_adapter_pkg::*;
(
    input  amo_op_e               amo_atop_i,
    input  logic [XLEN-1:0]       amo_wdata_i,
    input  logic [SIZE_WIDTH-1:0] amo_size_i,
    input  logic                  amo_word_hi_i,

    output cache_op_e             amo_op_o,
    output logic [XLEN-1:0]       amo_data_o,
    output logic [BE_WIDTH-1:0]   amo_be_o
);

    logic amo_is_word;

    // ------------------------------------------------------------------------
    // Opcode translation
    // ------------------------------------------------------------------------
    always_comb begin
        case (amo_atop_i)
            AMO_LR:   amo_op_o = REQ_AMO_LR;
            AMO_SC:   amo_op_o = REQ_AMO_SC;
            AMO_SWAP: amo_op_o = REQ_AMO_SWAP;
            AMO_ADD:  amo_op_o = REQ_AMO_ADD;
            AMO_AND:  amo_op_o = REQ_AMO_AND;
            AMO_OR:   amo_op_o = REQ_AMO_OR;
            AMO_XOR:  amo_op_o = REQ_AMO_XOR;
            AMO_MAX:  amo_op_o = REQ_AMO_MAX;
            AMO_MAXU: amo_op_o = REQ_AMO_MAXU;
            AMO_MIN:  amo_op_o = REQ_AMO_MIN;
            AMO_MINU: amo_op_o = REQ_AMO_MINU;
            // NONE and undefined codes fall back to a plain load
            default:  amo_op_o = REQ_LOAD;
        endcase
    end

    // ------------------------------------------------------------------------
    // Data and byte enable alignment
    // ------------------------------------------------------------------------
    assign amo_is_word = (amo_size_i == SIZE_WORD);

    // Word operand copied to both halves so either lane is valid
    assign amo_data_o = amo_is_word ? {2{amo_wdata_i[XLEN/2-1:0]}} : amo_wdata_i;

    always_comb begin
        if (!amo_is_word) begin
            amo_be_o = '1;
        end else if (amo_word_hi_i) begin
            amo_be_o = {{(BE_WIDTH/2){1'b1}}, {(BE_WIDTH/2){1'b0}}};
        end else begin
            amo_be_o = {{(BE_WIDTH/2){1'b0}}, {(BE_WIDTH/2){1'b1}}};
        end
    end

endmodule

//--- rtl/amo_response_tracker.sv
/*
 * AMO response tracker. Holds the single outstanding AMO flag, splits
 * cache responses by transaction ID and formats the AMO read data.
 */
module amo_response_tracker
    import hpdc_adapter_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  amo_accept_i,
    input  logic [SIZE_WIDTH-1:0] amo_size_i,
    input  logic                  amo_word_hi_i,

    input  logic                  rsp_valid_i,
    input  logic [TID_WIDTH-1:0]  rsp_tid_i,
    input  logic [XLEN-1:0]       rsp_rdata_i,

    output logic                  amo_pending_o,
    output logic                  amo_rvalid_o,
    output logic [XLEN-1:0]       amo_rdata_o,
    output logic                  store_rvalid_o
);

    logic               amo_pending_q;
    logic [XLEN/2-1:0]  rsp_word;

    // ------------------------------------------------------------------------
    // Response routing
    // ------------------------------------------------------------------------
    assign amo_rvalid_o   = rsp_valid_i && (rsp_tid_i == AMO_TID);
    assign store_rvalid_o = rsp_valid_i && (rsp_tid_i != AMO_TID);

    // Pick the addressed half, then sign extend for word AMOs
    assign rsp_word = amo_word_hi_i ? rsp_rdata_i[XLEN-1:XLEN/2] : rsp_rdata_i[XLEN/2-1:0];

    assign amo_rdata_o = (amo_size_i == SIZE_WORD)
                       ? {{(XLEN/2){rsp_word[XLEN/2-1]}}, rsp_word}
                       : rsp_rdata_i;

    // ------------------------------------------------------------------------
    // Outstanding AMO flag
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            amo_pending_q <= 1'b0;
        end else if (amo_accept_i) begin
            amo_pending_q <= 1'b1;
        end else if (amo_rvalid_o) begin
            amo_pending_q <= 1'b0;
        end
    end

    assign amo_pending_o = amo_pending_q;

endmodule

//--- rtl/cache_request_mux.sv
/*
 * Cache request multiplexer. Selects AMO, store or flush by fixed
 * priority, builds the request fields and returns the grants.
 */
module cache_request_mux
    import hpdc_adapter_pkg::*;
(
    input  logic                   store_preq_i,
    input  logic [PLEN-1:0]        store_paddr_i,
    input  logic [XLEN-1:0]        store_wdata_i,
    input  logic [BE_WIDTH-1:0]    store_be_i,
    input  logic [SIZE_WIDTH-1:0]  store_size_i,
    input  logic                   store_cacheable_i,

    input  logic                   amo_preq_i,
    input  logic                   amo_pending_i,
    input  logic [PLEN-1:0]        amo_paddr_i,
    input  cache_op_e              amo_op_i,
    input  logic [XLEN-1:0]        amo_data_i,
    input  logic [BE_WIDTH-1:0]    amo_be_i,
    input  logic [SIZE_WIDTH-1:0]  amo_size_i,
    input  logic                   amo_cacheable_i,

    input  logic                   flush_req_i,
    input  logic [SID_WIDTH-1:0]   hpdc_sid_i,
    input  logic                   req_ready_i,

    output logic                   req_valid_o,
    output logic [INDEX_WIDTH-1:0] req_addr_offset_o,
    output logic [TAG_WIDTH-1:0]   req_addr_tag_o,
    output logic [XLEN-1:0]        req_wdata_o,
    output cache_op_e              req_op_o,
    output logic [BE_WIDTH-1:0]    req_be_o,
    output logic [SIZE_WIDTH-1:0]  req_size_o,
    output logic [SID_WIDTH-1:0]   req_sid_o,
    output logic [TID_WIDTH-1:0]   req_tid_o,
    output logic                   req_need_rsp_o,
    output logic                   req_phys_indexed_o,
    output logic                   req_uncacheable_o,

    output logic                   store_pgnt_o,
    output logic                   amo_pgnt_o,
    output logic                   flush_gnt_o
);

    logic sel_amo, sel_store, sel_flush;

    // ------------------------------------------------------------------------
    // Fixed priority select
    // ------------------------------------------------------------------------
    // A pending AMO drops out of arbitration entirely
    assign sel_amo   = amo_preq_i && !amo_pending_i;
    assign sel_store = !sel_amo && store_preq_i;
    assign sel_flush = !sel_amo && !store_preq_i && flush_req_i;

    assign req_valid_o  = sel_amo || sel_store || sel_flush;
    assign amo_pgnt_o   = sel_amo && req_ready_i;
    assign store_pgnt_o = sel_store && req_ready_i;
    assign flush_gnt_o  = sel_flush && req_ready_i;

    assign req_sid_o = hpdc_sid_i;

    // ------------------------------------------------------------------------
    // Request fields
    // ------------------------------------------------------------------------
    always_comb begin
        if (sel_amo) begin
            req_addr_offset_o  = amo_paddr_i[INDEX_WIDTH-1:0];
            req_addr_tag_o     = amo_paddr_i[PLEN-1:INDEX_WIDTH];
            req_wdata_o        = amo_data_i;
            req_op_o           = amo_op_i;
            req_be_o           = amo_be_i;
            req_size_o         = amo_size_i;
            req_tid_o          = AMO_TID;
            req_need_rsp_o     = 1'b1;
            req_phys_indexed_o = 1'b1;
            req_uncacheable_o  = !amo_cacheable_i;
        end else if (sel_store) begin
            req_addr_offset_o  = store_paddr_i[INDEX_WIDTH-1:0];
            req_addr_tag_o     = store_paddr_i[PLEN-1:INDEX_WIDTH];
            req_wdata_o        = store_wdata_i;
            req_op_o           = REQ_STORE;
            req_be_o           = store_be_i;
            req_size_o         = store_size_i;
            req_tid_o          = STORE_TID;
            req_need_rsp_o     = 1'b0;
            req_phys_indexed_o = 1'b1;
            req_uncacheable_o  = !store_cacheable_i;
        end else begin
            // Flush fields, also the idle default
            req_addr_offset_o  = '0;
            req_addr_tag_o     = '0;
            req_wdata_o        = '0;
            req_op_o           = INVALIDATE_ON_FLUSH ? REQ_FLUSH_INVAL_ALL : REQ_FLUSH_ALL;
            req_be_o           = '0;
            req_size_o         = '0;
            req_tid_o          = STORE_TID;
            req_need_rsp_o     = 1'b1;
            req_phys_indexed_o = 1'b0;
            req_uncacheable_o  = 1'b0;
        end
    end

endmodule

//--- rtl/flush_sequencer.sv
/*
 * Flush sequencer. Issues one whole-cache flush per core request and
 * acknowledges it when the cache answers with the store ID.
 */
module flush_sequencer
    import hpdc_adapter_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 flush_i,
    input  logic                 flush_gnt_i,
    input  logic                 rsp_valid_i,
    input  logic [TID_WIDTH-1:0] rsp_tid_i,

    output logic                 flush_req_o,
    output logic                 flush_ack_o
);

    flush_state_e state_q, state_d;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= FLUSH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d     = state_q;
        flush_req_o = 1'b0;
        flush_ack_o = 1'b0;

        case (state_q)
            FLUSH_IDLE: begin
                flush_req_o = flush_i;
                // Only our own grant moves us on
                if (flush_gnt_i) begin
                    state_d = FLUSH_PEND;
                end
            end
            FLUSH_PEND: begin
                if (rsp_valid_i && (rsp_tid_i == STORE_TID)) begin
                    flush_ack_o = 1'b1;
                    state_d     = FLUSH_IDLE;
                end
            end
            default: begin
                state_d = FLUSH_IDLE;
            end
        endcase
    end

endmodule

//--- rtl/hpdc_adapter_pkg.sv
/*
 * Shared definitions for the store-side cache adapter: widths,
 * transaction IDs, opcode and state encodings, and the flush policy.
 */
package hpdc_adapter_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int XLEN        = 64;
    localparam int PLEN        = 32;
    localparam int INDEX_WIDTH = 12;
    localparam int TAG_WIDTH   = PLEN - INDEX_WIDTH;
    localparam int BE_WIDTH    = XLEN / 8;
    localparam int SIZE_WIDTH  = 2;
    localparam int SID_WIDTH   = 3;
    localparam int TID_WIDTH   = 4;

    // Log2 of a 32-bit access
    localparam logic [SIZE_WIDTH-1:0] SIZE_WORD = 2'd2;

    // Transaction IDs, responses are routed by these
    localparam logic [TID_WIDTH-1:0] AMO_TID   = '1;
    localparam logic [TID_WIDTH-1:0] STORE_TID = '0;

    // Flush with invalidate when set
    localparam bit INVALIDATE_ON_FLUSH = 1'b0;

    // ------------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------------
    // Atomic opcodes as issued by the core
    typedef enum logic [3:0] {
        AMO_NONE,
        AMO_LR,
        AMO_SC,
        AMO_SWAP,
        AMO_ADD,
        AMO_AND,
        AMO_OR,
        AMO_XOR,
        AMO_MAX,
        AMO_MAXU,
        AMO_MIN,
        AMO_MINU
    } amo_op_e;

    // Cache request opcodes
    typedef enum logic [3:0] {
        REQ_LOAD,
        REQ_STORE,
        REQ_AMO_LR,
        REQ_AMO_SC,
        REQ_AMO_SWAP,
        REQ_AMO_ADD,
        REQ_AMO_AND,
        REQ_AMO_OR,
        REQ_AMO_XOR,
        REQ_AMO_MAX,
        REQ_AMO_MAXU,
        REQ_AMO_MIN,
        REQ_AMO_MINU,
        REQ_FLUSH_ALL,
        REQ_FLUSH_INVAL_ALL
    } cache_op_e;

    // Flush sequencer states
    typedef enum logic {
        FLUSH_IDLE,
        FLUSH_PEND
    } flush_state_e;

endpackage

//--- rtl/hpdc_store_adapter.sv
/*
 * Store-side cache adapter. Connects the core store, AMO and flush
 * channels to the L1 data cache request and response ports.
 */
module hpdc_store_adapter
    import hpdc_adapter_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [SID_WIDTH-1:0]   hpdc_sid_i,

    // Store channel
    input  logic                   store_preq_i,
    input  logic [PLEN-1:0]        store_paddr_i,
    input  logic [XLEN-1:0]        store_wdata_i,
    input  logic [BE_WIDTH-1:0]    store_be_i,
    input  logic [SIZE_WIDTH-1:0]  store_size_i,
    input  logic                   store_cacheable_i,
    output logic                   store_pgnt_o,
    output logic                   store_rvalid_o,

    // AMO channel
    input  logic                   amo_preq_i,
    input  amo_op_e                amo_atop_i,
    input  logic [PLEN-1:0]        amo_paddr_i,
    input  logic [XLEN-1:0]        amo_wdata_i,
    input  logic [SIZE_WIDTH-1:0]  amo_size_i,
    input  logic                   amo_cacheable_i,
    output logic                   amo_pgnt_o,
    output logic                   amo_rvalid_o,
    output logic [XLEN-1:0]        amo_rdata_o,

    // Flush
    input  logic                   flush_i,
    output logic                   flush_ack_o,

    // Cache request port
    output logic                   req_valid_o,
    input  logic                   req_ready_i,
    output logic [INDEX_WIDTH-1:0] req_addr_offset_o,
    output logic [TAG_WIDTH-1:0]   req_addr_tag_o,
    output logic [XLEN-1:0]        req_wdata_o,
    output cache_op_e              req_op_o,
    output logic [BE_WIDTH-1:0]    req_be_o,
    output logic [SIZE_WIDTH-1:0]  req_size_o,
    output logic [SID_WIDTH-1:0]   req_sid_o,
    output logic [TID_WIDTH-1:0]   req_tid_o,
    output logic                   req_need_rsp_o,
    output logic                   req_phys_indexed_o,
    output logic                   req_uncacheable_o,

    // Cache response port
    input  logic                   rsp_valid_i,
    input  logic [TID_WIDTH-1:0]   rsp_tid_i,
    input  logic [XLEN-1:0]        rsp_rdata_i
);

    logic                amo_word_hi;
    cache_op_e           amo_op;
    logic [XLEN-1:0]     amo_data;
    logic [BE_WIDTH-1:0] amo_be;
    logic                amo_pending;
    logic                flush_req;
    logic                flush_gnt;

    // Word lane select for both AMO directions
    assign amo_word_hi = amo_paddr_i[2];

    amo_request_encoder u_amo_enc (
        .amo_atop_i    (amo_atop_i),
        .amo_wdata_i   (amo_wdata_i),
        .amo_size_i    (amo_size_i),
        .amo_word_hi_i (amo_word_hi),
        .amo_op_o      (amo_op),
        .amo_data_o    (amo_data),
        .amo_be_o      (amo_be)
    );

    amo_response_tracker u_amo_rsp (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .amo_accept_i   (amo_pgnt_o),
        .amo_size_i     (amo_size_i),
        .amo_word_hi_i  (amo_word_hi),
        .rsp_valid_i    (rsp_valid_i),
        .rsp_tid_i      (rsp_tid_i),
        .rsp_rdata_i    (rsp_rdata_i),
        .amo_pending_o  (amo_pending),
        .amo_rvalid_o   (amo_rvalid_o),
        .amo_rdata_o    (amo_rdata_o),
        .store_rvalid_o (store_rvalid_o)
    );

    flush_sequencer u_flush (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .flush_gnt_i (flush_gnt),
        .rsp_valid_i (rsp_valid_i),
        .rsp_tid_i   (rsp_tid_i),
        .flush_req_o (flush_req),
        .flush_ack_o (flush_ack_o)
    );

    cache_request_mux u_req_mux (
        .store_preq_i       (store_preq_i),
        .store_paddr_i      (store_paddr_i),
        .store_wdata_i      (store_wdata_i),
        .store_be_i         (store_be_i),
        .store_size_i       (store_size_i),
        .store_cacheable_i  (store_cacheable_i),
        .amo_preq_i         (amo_preq_i),
        .amo_pending_i      (amo_pending),
        .amo_paddr_i        (amo_paddr_i),
        .amo_op_i           (amo_op),
        .amo_data_i         (amo_data),
        .amo_be_i           (amo_be),
        .amo_size_i         (amo_size_i),
        .amo_cacheable_i    (amo_cacheable_i),
        .flush_req_i        (flush_req),
        .hpdc_sid_i         (hpdc_sid_i),
        .req_ready_i        (req_ready_i),
        .req_valid_o        (req_valid_o),
        .req_addr_offset_o  (req_addr_offset_o),
        .req_addr_tag_o     (req_addr_tag_o),
        .req_wdata_o        (req_wdata_o),
        .req_op_o           (req_op_o),
        .req_be_o           (req_be_o),
        .req_size_o         (req_size_o),
        .req_sid_o          (req_sid_o),
        .req_tid_o          (req_tid_o),
        .req_need_rsp_o     (req_need_rsp_o),
        .req_phys_indexed_o (req_phys_indexed_o),
        .req_uncacheable_o  (req_uncacheable_o),
        .store_pgnt_o       (store_pgnt_o),
        .amo_pgnt_o         (amo_pgnt_o),
        .flush_gnt_o        (flush_gnt)
    );

endmodule

//--- testbench/tb_hpdc_store_adapter.sv
/*
 * Testbench for the store-side cache adapter. Random core traffic and a
 * cache model, with every cycle checked against reference functions.
 */
module tb_hpdc_store_adapter
    import hpdc_adapter_pkg::*;
();

    localparam int NUM_TXN        = 200;
    localparam int TIMEOUT_CYCLES = NUM_TXN * 12 + 100;
    localparam logic [SIZE_WIDTH-1:0] SIZE_DWORD = 2'd3;
    localparam cache_op_e FLUSH_OP = INVALIDATE_ON_FLUSH ? REQ_FLUSH_INVAL_ALL : REQ_FLUSH_ALL;

    logic clk_i, rst_ni;
    logic [SID_WIDTH-1:0] hpdc_sid_i, req_sid_o;
    logic store_preq_i, store_cacheable_i, store_pgnt_o, store_rvalid_o;
    logic [PLEN-1:0] store_paddr_i, amo_paddr_i;
    logic [XLEN-1:0] store_wdata_i, amo_wdata_i, amo_rdata_o, req_wdata_o, rsp_rdata_i;
    logic [BE_WIDTH-1:0] store_be_i, req_be_o;
    logic [SIZE_WIDTH-1:0] store_size_i, amo_size_i, req_size_o;
    logic amo_preq_i, amo_cacheable_i, amo_pgnt_o, amo_rvalid_o;
    amo_op_e amo_atop_i;
    logic flush_i, flush_ack_o;
    logic req_valid_o, req_ready_i, req_need_rsp_o, req_phys_indexed_o, req_uncacheable_o;
    logic [INDEX_WIDTH-1:0] req_addr_offset_o;
    logic [TAG_WIDTH-1:0] req_addr_tag_o;
    cache_op_e req_op_o;
    logic [TID_WIDTH-1:0] req_tid_o, rsp_tid_i;
    logic rsp_valid_i;

    // Testbench state
    logic [31:0] lfsr_q;
    int cycle, txn_count, amo_issued;
    logic amo_pend_m, flush_pend_m;
    logic e_amo, e_store, e_flush;
    logic store_taken, amo_done, flush_done;
    logic rsp_amo;
    // Set for an AMO answer, clear for a flush answer
    logic amo_rsp_q[$];
    int due_q[$];

    hpdc_store_adapter UUT (.*);

    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // Random source and reference functions
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // Taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Cache list runs one entry behind the core list, LR through MINU
    function automatic cache_op_e exp_cache_op(input amo_op_e op);
        if (op >= AMO_LR && op <= AMO_MINU) begin
            return cache_op_e'(4'(op) + 4'd1);
        end
        return REQ_LOAD;
    endfunction

    function automatic logic [XLEN-1:0] exp_amo_data(input logic [XLEN-1:0] d,
                                                     input logic [SIZE_WIDTH-1:0] size);
        return (size == SIZE_WORD) ? {d[31:0], d[31:0]} : d;
    endfunction

    function automatic logic [BE_WIDTH-1:0] exp_amo_be(input logic [SIZE_WIDTH-1:0] size,
                                                       input logic hi);
        if (size != SIZE_WORD) begin
            return 8'hff;
        end
        return hi ? 8'hf0 : 8'h0f;
    endfunction

    function automatic logic [XLEN-1:0] exp_amo_rdata(input logic [XLEN-1:0] r,
                                                      input logic [SIZE_WIDTH-1:0] size,
                                                      input logic hi);
        if (size != SIZE_WORD) begin
            return r;
        end
        return hi ? 64'($signed(r[63:32])) : 64'($signed(r[31:0]));
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_vec(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_op(input string name, input cache_op_e got, input cache_op_e exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED t=%0t %s got %s expected %s",
                                $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_request(input logic [PLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                                 input cache_op_e op, input logic [BE_WIDTH-1:0] be,
                                 input logic [SIZE_WIDTH-1:0] size,
                                 input logic [TID_WIDTH-1:0] tid, input logic need_rsp,
                                 input logic phys, input logic unc);
        check_vec("req_addr_offset_o", req_addr_offset_o, addr % (1 << INDEX_WIDTH));
        check_vec("req_addr_tag_o", req_addr_tag_o, addr >> INDEX_WIDTH);
        check_vec("req_wdata_o", req_wdata_o, wdata);
        check_op("req_op_o", req_op_o, op);
        check_vec("req_be_o", req_be_o, be);
        check_vec("req_size_o", req_size_o, size);
        check_vec("req_tid_o", req_tid_o, tid);
        check_bit("req_need_rsp_o", req_need_rsp_o, need_rsp);
        check_bit("req_phys_indexed_o", req_phys_indexed_o, phys);
        check_bit("req_uncacheable_o", req_uncacheable_o, unc);
    endtask

    // ------------------------------------------------------------------------
    // Compare process, cache model intake and timeout
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_ni) begin
            cycle++;
            if (cycle > TIMEOUT_CYCLES) begin
                abort_run($sformatf("Timeout after %0d cycles with %0d of %0d transactions done",
                                    cycle, txn_count, NUM_TXN));
            end
            e_amo   = amo_preq_i && !amo_pend_m;
            e_store = !e_amo && store_preq_i;
            e_flush = !e_amo && !store_preq_i && flush_i && !flush_pend_m;

            check_bit("req_valid_o", req_valid_o, e_amo || e_store || e_flush);
            check_bit("amo_pgnt_o", amo_pgnt_o, e_amo && req_ready_i);
            check_bit("store_pgnt_o", store_pgnt_o, e_store && req_ready_i);
            check_vec("req_sid_o", req_sid_o, hpdc_sid_i);
            if (e_amo) begin
                check_request(amo_paddr_i, exp_amo_data(amo_wdata_i, amo_size_i),
                              exp_cache_op(amo_atop_i), exp_amo_be(amo_size_i, amo_paddr_i[2]),
                              amo_size_i, AMO_TID, 1'b1, 1'b1, !amo_cacheable_i);
            end else if (e_store) begin
                check_request(store_paddr_i, store_wdata_i, REQ_STORE, store_be_i, store_size_i,
                              STORE_TID, 1'b0, 1'b1, !store_cacheable_i);
            end else if (e_flush) begin
                check_request('0, '0, FLUSH_OP, '0, '0, STORE_TID, 1'b1, 1'b0, 1'b0);
            end

            // Response side, all in the cycle of the cache answer
            check_bit("amo_rvalid_o", amo_rvalid_o, rsp_valid_i && rsp_amo);
            check_bit("store_rvalid_o", store_rvalid_o, rsp_valid_i && !rsp_amo);
            check_bit("flush_ack_o", flush_ack_o, rsp_valid_i && !rsp_amo);
            if (rsp_valid_i && rsp_amo) begin
                check_vec("amo_rdata_o", amo_rdata_o,
                          exp_amo_rdata(rsp_rdata_i, amo_size_i, amo_paddr_i[2]));
            end

            // Cache model takes the request
            if ((e_amo || e_flush) && req_ready_i) begin
                amo_rsp_q.push_back(e_amo);
                due_q.push_back(cycle + 1 + int'(rand_bits(3) % 6));
            end
            if ((e_amo || e_store || e_flush) && req_ready_i) begin
                txn_count++;
            end
            if (e_amo && req_ready_i) begin
                amo_pend_m = 1'b1;
            end else if (rsp_valid_i && rsp_amo) begin
                amo_pend_m = 1'b0;
            end
            if (e_flush && req_ready_i) begin
                flush_pend_m = 1'b1;
            end else if (rsp_valid_i && !rsp_amo) begin
                flush_pend_m = 1'b0;
            end
            store_taken = e_store && req_ready_i;
            amo_done    = rsp_valid_i && rsp_amo;
            flush_done  = rsp_valid_i && !rsp_amo;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus, driven on the falling edge
    // ------------------------------------------------------------------------
    task automatic drive_cycle();
        rsp_valid_i = 1'b0;
        rsp_tid_i   = '0;
        rsp_rdata_i = '0;
        rsp_amo     = 1'b0;
        if (amo_rsp_q.size() != 0 && due_q[0] <= cycle) begin
            rsp_valid_i = 1'b1;
            rsp_amo     = amo_rsp_q.pop_front();
            rsp_tid_i   = rsp_amo ? AMO_TID : STORE_TID;
            void'(due_q.pop_front());
            if (rsp_amo) begin
                rsp_rdata_i = rand_bits(XLEN);
            end
        end
        // Core retires finished requests
        if (store_taken) begin
            store_preq_i = 1'b0;
        end
        if (amo_done) begin
            amo_preq_i = 1'b0;
        end
        if (flush_done) begin
            flush_i = 1'b0;
        end
        if (txn_count < NUM_TXN) begin
            if (!store_preq_i && rand_bits(2) == 0) begin
                store_preq_i      = 1'b1;
                store_paddr_i     = PLEN'(rand_bits(PLEN));
                store_wdata_i     = rand_bits(XLEN);
                store_be_i        = BE_WIDTH'(rand_bits(BE_WIDTH));
                store_size_i      = SIZE_WIDTH'(rand_bits(SIZE_WIDTH));
                store_cacheable_i = 1'(rand_bits(1));
            end
            // Opcode sweep, each code seen with both sizes
            if (!amo_preq_i && rand_bits(2) == 0) begin
                amo_preq_i      = 1'b1;
                amo_atop_i      = amo_op_e'(4'((amo_issued / 2) % 16));
                amo_size_i      = (amo_issued % 2 == 1) ? SIZE_WORD : SIZE_DWORD;
                amo_paddr_i     = PLEN'(rand_bits(PLEN));
                amo_wdata_i     = rand_bits(XLEN);
                amo_cacheable_i = 1'(rand_bits(1));
                amo_issued++;
            end
            if (!flush_i && rand_bits(3) == 0) begin
                flush_i = 1'b1;
            end
        end
        req_ready_i = (rand_bits(2) != 0);
    endtask

    initial begin
        clk_i = 1'b0;
        rst_ni = 1'b0;
        lfsr_q = 32'h2e9b_4561;
        store_preq_i = 1'b0;
        store_paddr_i = '0;
        store_wdata_i = '0;
        store_be_i = '0;
        store_size_i = '0;
        store_cacheable_i = 1'b0;
        amo_preq_i = 1'b0;
        amo_atop_i = AMO_NONE;
        amo_paddr_i = '0;
        amo_wdata_i = '0;
        amo_size_i = '0;
        amo_cacheable_i = 1'b0;
        flush_i = 1'b0;
        req_ready_i = 1'b0;
        rsp_valid_i = 1'b0;
        rsp_tid_i = '0;
        rsp_rdata_i = '0;
        rsp_amo = 1'b0;
        cycle = 0;
        txn_count = 0;
        amo_issued = 0;
        amo_pend_m = 1'b0;
        flush_pend_m = 1'b0;
        store_taken = 1'b0;
        amo_done = 1'b0;
        flush_done = 1'b0;
        hpdc_sid_i = SID_WIDTH'(rand_bits(SID_WIDTH));

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        do begin
            drive_cycle();
            @(negedge clk_i);
        end while (txn_count < NUM_TXN || store_preq_i || amo_preq_i || flush_i
                   || amo_rsp_q.size() != 0);
        drive_cycle();
        // A few idle cycles still go through the checks
        repeat (3) @(negedge clk_i);
        $display("Simulation passed");
        $finish;
    end

endmodule
